//--- src/life_geom_pkg.sv
//////////////////////////////
// 16x16 grid, one row per memory word
// row count and width must stay in step with ADDR_W
//////////////////////////////
`default_nettype none

package life_geom_pkg;

	// grid size
	localparam int GRID_W = 16;
	localparam int GRID_H = 16;
	localparam int ADDR_W = 4;

	// one row of cells, bit i is column i
	typedef logic [GRID_W-1:0] row_t;
	typedef logic [ADDR_W-1:0] addr_t;

	// row counter, one bit wider so it can reach GRID_H
	typedef logic [ADDR_W:0] count_t;
	localparam count_t LAST_ROW = count_t'(GRID_H - 1);
	localparam count_t ROW_COUNT = count_t'(GRID_H);

endpackage

`default_nettype wire

//--- src/life_ctrl_pkg.sv
//////////////////////////////
// opcode 2'b11 is unused and is dropped on acceptance
//////////////////////////////
`default_nettype none

package life_ctrl_pkg;

	// command opcodes
	typedef enum logic [1:0] {
		CMD_SEED = 2'd0,
		CMD_STEP = 2'd1,
		CMD_READ = 2'd2
	} cmd_e;

	// sequencer states
	typedef enum logic [2:0] {
		S_IDLE  = 3'd0,
		S_SEED  = 3'd1,
		S_STEP  = 3'd2,
		S_DRAIN = 3'd3,
		S_READ  = 3'd4
	} seq_state_e;

	// lfsr start value, any nonzero word
	localparam logic [15:0] LFSR_SEED = 16'hace1;

	// read-out credits, sized to the consumer buffer
	localparam int CREDIT_W = 3;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 3'd4;

endpackage

`default_nettype wire

//--- src/cell_mem_if.sv
//////////////////////////////
// rdata shows last cycle's raddr, old word on collision
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface cell_mem_if ();

	life_geom_pkg::addr_t raddr;
	life_geom_pkg::addr_t waddr;
	logic we;
	life_geom_pkg::row_t wdata;
	life_geom_pkg::row_t rdata;

	// memory side
	modport ram (input raddr, input waddr, input we, input wdata, output rdata);
	// address and write source
	modport seq (output raddr, output waddr, output we, output wdata);
	// read data consumers
	modport pipe (input rdata);
	modport out (input rdata);

endinterface

`default_nettype wire

//--- src/cell_ram.sv
//////////////////////////////
// contents undefined until the first seed
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cell_ram (
	input logic clk,
	cell_mem_if.ram mem
);

	// one word per grid row
	life_geom_pkg::row_t cells [life_geom_pkg::GRID_H];

	//////////////////////////////
	// write and registered read
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (mem.we) begin
			cells[mem.waddr] <= mem.wdata;
		end
		// nonblocking, so a same-address read sees the old word
		mem.rdata <= cells[mem.raddr];
	end

endmodule

`default_nettype wire

//--- src/seed_lfsr.sv
//////////////////////////////
// taps fixed for a 16-cell row, never cleared between seeds
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module seed_lfsr (
	input logic clk,
	input logic reset,
	input logic advance,
	output life_geom_pkg::row_t row
);

	logic feedback;

	// taps at bits 0, 2, 3, 5 of the current row
	assign feedback = row[0] ^ row[2] ^ row[3] ^ row[5];

	always_ff @(posedge clk) begin
		if (reset) begin
			row <= life_ctrl_pkg::LFSR_SEED;
		end else if (advance) begin
			// shift toward bit 0, new top bit
			row <= {feedback, row[life_geom_pkg::GRID_W-1:1]};
		end
	end

endmodule

`default_nettype wire

//--- src/life_rule_pipe.sv
//////////////////////////////
// feed to next_valid is 3 cycles, columns wrap
// rows outside the grid enter as pad or via clear
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_rule_pipe (
	input logic clk,
	input logic clear,
	input logic feed,
	input logic pad,
	cell_mem_if.pipe mem,
	output life_geom_pkg::row_t next_row,
	output logic next_valid
);

	// window, win_mid is the row being evaluated
	life_geom_pkg::row_t win_new;
	life_geom_pkg::row_t win_mid;
	life_geom_pkg::row_t win_old;
	logic win_valid;
	// stage 1, three-row column sums
	logic [life_geom_pkg::GRID_W-1:0][1:0] col_sum;
	logic [life_geom_pkg::GRID_W-1:0][1:0] col_sum_q;
	life_geom_pkg::row_t mid_q;
	logic sum_valid;
	// stage 2
	life_geom_pkg::row_t rule_row;

	//////////////////////////////
	// row window
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (clear) begin
			win_new <= '0;
			win_mid <= '0;
			win_old <= '0;
			win_valid <= 1'b0;
		end else begin
			win_valid <= feed;
			if (feed) begin
				win_old <= win_mid;
				win_mid <= win_new;
				// dead row below the last grid row
				win_new <= pad ? '0 : mem.rdata;
			end
		end
	end

	always_comb begin
		for (int i = 0; i < life_geom_pkg::GRID_W; i++) begin
			col_sum[i] = {1'b0, win_old[i]} + {1'b0, win_mid[i]} + {1'b0, win_new[i]};
		end
	end

	// sums and centre row move on together
	always_ff @(posedge clk) begin
		col_sum_q <= col_sum;
		mid_q <= win_mid;
	end

	//////////////////////////////
	// 3x3 total and life rule
	//////////////////////////////

	always_comb begin
		logic [3:0] total;
		total = '0;
		for (int i = 0; i < life_geom_pkg::GRID_W; i++) begin
			// neighbour columns wrap at both edges
			total = {2'b00, col_sum_q[(i + 1) % life_geom_pkg::GRID_W]}
				+ {2'b00, col_sum_q[i]}
				+ {2'b00, col_sum_q[(i + life_geom_pkg::GRID_W - 1) % life_geom_pkg::GRID_W]};
			// total counts the cell itself: 3 births or survives, 4 survives only
			rule_row[i] = (total == 4'd3) || ((total == 4'd4) && mid_q[i]);
		end
	end

	always_ff @(posedge clk) begin
		next_row <= rule_row;
	end

	// valid chain follows the payload
	always_ff @(posedge clk) begin
		if (clear) begin
			sum_valid <= 1'b0;
			next_valid <= 1'b0;
		end else begin
			sum_valid <= win_valid;
			next_valid <= sum_valid;
		end
	end

endmodule

`default_nettype wire

//--- src/life_seq.sv
//////////////////////////////
// one command at a time, accepted only in idle
// step result is written back 4 cycles after the read
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_seq (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input life_ctrl_pkg::cmd_e cmd,
	output logic cmd_ready,
	output logic [31:0] gen_count,
	cell_mem_if.seq mem,
	input life_geom_pkg::row_t seed_row,
	output logic seed_advance,
	output logic pipe_clear,
	output logic pipe_feed,
	output logic pipe_pad,
	input life_geom_pkg::row_t next_row,
	input logic next_valid,
	input logic credit_ok,
	output logic issue,
	output life_geom_pkg::addr_t issue_addr
);

	life_ctrl_pkg::seq_state_e state;
	// seed write, step read or read-out index
	life_geom_pkg::count_t cnt;
	life_geom_pkg::count_t cnt_next;
	// step write-back index
	life_geom_pkg::count_t wr_row;
	// first window of a step is centred above row 0
	logic skip_done;
	logic stepping;
	logic step_we;
	logic last_write;
	// read strobe delayed to line up with rdata
	logic feed_q;
	logic pad_q;

	assign cnt_next = cnt + 1'b1;
	assign cmd_ready = (state == life_ctrl_pkg::S_IDLE);
	assign pipe_clear = (state == life_ctrl_pkg::S_IDLE);
	assign pipe_feed = feed_q;
	assign pipe_pad = pad_q;
	assign seed_advance = (state == life_ctrl_pkg::S_SEED);

	assign stepping = (state == life_ctrl_pkg::S_STEP) || (state == life_ctrl_pkg::S_DRAIN);
	assign step_we = stepping && next_valid && skip_done;
	assign last_write = step_we && (wr_row == life_geom_pkg::LAST_ROW);

	// read-out, only with a free credit
	assign issue = (state == life_ctrl_pkg::S_READ) && credit_ok;
	assign issue_addr = cnt[life_geom_pkg::ADDR_W-1:0];

	//////////////////////////////
	// memory port
	//////////////////////////////

	always_comb begin
		mem.raddr = '0;
		mem.waddr = wr_row[life_geom_pkg::ADDR_W-1:0];
		mem.we = step_we;
		mem.wdata = next_row;
		case (state)
			life_ctrl_pkg::S_SEED: begin
				mem.waddr = cnt[life_geom_pkg::ADDR_W-1:0];
				mem.we = 1'b1;
				mem.wdata = seed_row;
			end
			life_ctrl_pkg::S_STEP: begin
				mem.raddr = cnt[life_geom_pkg::ADDR_W-1:0];
			end
			life_ctrl_pkg::S_READ: begin
				// look one row ahead so rdata is ready for back-to-back issues
				mem.raddr = issue ? cnt_next[life_geom_pkg::ADDR_W-1:0]
					: cnt[life_geom_pkg::ADDR_W-1:0];
			end
			default: begin
			end
		endcase
	end

	//////////////////////////////
	// state machine
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= life_ctrl_pkg::S_IDLE;
			cnt <= '0;
			wr_row <= '0;
			skip_done <= 1'b0;
			feed_q <= 1'b0;
			pad_q <= 1'b0;
			gen_count <= '0;
		end else begin
			feed_q <= (state == life_ctrl_pkg::S_STEP);
			pad_q <= (state == life_ctrl_pkg::S_STEP) && (cnt == life_geom_pkg::ROW_COUNT);
			if (stepping && next_valid) begin
				skip_done <= 1'b1;
			end
			if (step_we) begin
				wr_row <= wr_row + 1'b1;
			end
			// generation done on the write of the last row
			if (last_write) begin
				gen_count <= gen_count + 32'd1;
			end
			case (state)
				life_ctrl_pkg::S_IDLE: begin
					cnt <= '0;
					wr_row <= '0;
					skip_done <= 1'b0;
					if (cmd_valid && cmd_ready) begin
						case (cmd)
							life_ctrl_pkg::CMD_SEED: state <= life_ctrl_pkg::S_SEED;
							life_ctrl_pkg::CMD_STEP: state <= life_ctrl_pkg::S_STEP;
							life_ctrl_pkg::CMD_READ: state <= life_ctrl_pkg::S_READ;
							// unused opcode, taken and dropped
							default: state <= life_ctrl_pkg::S_IDLE;
						endcase
					end
				end
				life_ctrl_pkg::S_SEED: begin
					cnt <= cnt_next;
					if (cnt == life_geom_pkg::LAST_ROW) begin
						state <= life_ctrl_pkg::S_IDLE;
					end
				end
				life_ctrl_pkg::S_STEP: begin
					// rows 0..GRID_H-1, then one pad slot
					cnt <= cnt_next;
					if (cnt == life_geom_pkg::ROW_COUNT) begin
						state <= life_ctrl_pkg::S_DRAIN;
					end
				end
				life_ctrl_pkg::S_DRAIN: begin
					if (last_write) begin
						state <= life_ctrl_pkg::S_IDLE;
					end
				end
				life_ctrl_pkg::S_READ: begin
					if (issue) begin
						cnt <= cnt_next;
						if (cnt == life_geom_pkg::LAST_ROW) begin
							state <= life_ctrl_pkg::S_IDLE;
						end
					end
				end
				default: state <= life_ctrl_pkg::S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/row_credit_out.sv
//////////////////////////////
// consumer returns one credit per row it frees
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module row_credit_out (
	input logic clk,
	input logic reset,
	input logic issue,
	input logic credit_return,
	input life_geom_pkg::addr_t issue_addr,
	cell_mem_if.out mem,
	output logic credit_ok,
	output logic row_valid,
	output life_geom_pkg::addr_t row_addr,
	output life_geom_pkg::row_t row_data
);

	logic [life_ctrl_pkg::CREDIT_W-1:0] credits;

	assign credit_ok = (credits != '0);

	// credit count and valid strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= life_ctrl_pkg::CREDIT_MAX;
			row_valid <= 1'b0;
		end else begin
			row_valid <= issue;
			case ({issue, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				// both or neither, count holds
				default: credits <= credits;
			endcase
		end
	end

	// output row register, loaded on issue
	always_ff @(posedge clk) begin
		if (issue) begin
			row_data <= mem.rdata;
			row_addr <= issue_addr;
		end
	end

endmodule

`default_nettype wire

//--- src/life_top.sv
//////////////////////////////
// single clock, sync active-high reset
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_top (
	input logic clk,
	input logic reset,
	input logic cmd_valid,
	input logic [1:0] cmd,
	output logic cmd_ready,
	input logic credit_return,
	output logic row_valid,
	output life_geom_pkg::addr_t row_addr,
	output life_geom_pkg::row_t row_data,
	output logic [31:0] gen_count
);

	// seed source
	life_geom_pkg::row_t seed_row;
	logic seed_advance;
	// rule pipeline
	logic pipe_clear;
	logic pipe_feed;
	logic pipe_pad;
	life_geom_pkg::row_t next_row;
	logic next_valid;
	// read-out
	logic credit_ok;
	logic issue;
	life_geom_pkg::addr_t issue_addr;

	cell_mem_if mem_bus ();

	cell_ram u_ram (
		.clk(clk),
		.mem(mem_bus.ram)
	);

	seed_lfsr u_lfsr (
		.clk(clk),
		.reset(reset),
		.advance(seed_advance),
		.row(seed_row)
	);

	life_rule_pipe u_pipe (
		.clk(clk),
		.clear(pipe_clear),
		.feed(pipe_feed),
		.pad(pipe_pad),
		.mem(mem_bus.pipe),
		.next_row(next_row),
		.next_valid(next_valid)
	);

	life_seq u_seq (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(life_ctrl_pkg::cmd_e'(cmd)),
		.cmd_ready(cmd_ready),
		.gen_count(gen_count),
		.mem(mem_bus.seq),
		.seed_row(seed_row),
		.seed_advance(seed_advance),
		.pipe_clear(pipe_clear),
		.pipe_feed(pipe_feed),
		.pipe_pad(pipe_pad),
		.next_row(next_row),
		.next_valid(next_valid),
		.credit_ok(credit_ok),
		.issue(issue),
		.issue_addr(issue_addr)
	);

	row_credit_out u_out (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.credit_return(credit_return),
		.issue_addr(issue_addr),
		.mem(mem_bus.out),
		.credit_ok(credit_ok),
		.row_valid(row_valid),
		.row_addr(row_addr),
		.row_data(row_data)
	);

endmodule

`default_nettype wire

//--- tb/life_tb.sv
//////////////////////////////
// consumer side returns one credit per row received
// every task starts and ends 2 ns after a rising edge
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module life_tb;

	localparam int TIMEOUT = 600;
	localparam int ROWS = life_geom_pkg::GRID_H;
	localparam int COLS = life_geom_pkg::GRID_W;

	logic clk;
	logic reset;
	logic cmd_valid;
	logic [1:0] cmd;
	logic cmd_ready;
	logic credit_return;
	logic row_valid;
	life_geom_pkg::addr_t row_addr;
	life_geom_pkg::row_t row_data;
	logic [31:0] gen_count;

	// software reference of the grid and the seed source
	life_geom_pkg::row_t model [ROWS];
	logic [15:0] lfsr_state;
	logic [31:0] gen_expected;

	life_top uut (
		.clk(clk),
		.reset(reset),
		.cmd_valid(cmd_valid),
		.cmd(cmd),
		.cmd_ready(cmd_ready),
		.credit_return(credit_return),
		.row_valid(row_valid),
		.row_addr(row_addr),
		.row_data(row_data),
		.gen_count(gen_count)
	);

	// 40 ns period
	always #20 clk = ~clk;

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic fail_stop();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("error at %0d ns: %s expected %0h, got %0h", $time, name, exp, got);
			fail_stop();
		end
	endtask

	//////////////////////////////
	// reference models
	//////////////////////////////

	// shift toward bit 0, taps 0 2 3 5 feed the top bit
	function automatic logic [15:0] lfsr_next(input logic [15:0] v);
		return {v[0] ^ v[2] ^ v[3] ^ v[5], v[15:1]};
	endfunction

	task automatic model_seed();
		for (int r = 0; r < ROWS; r++) begin
			model[r] = lfsr_state;
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// columns wrap, rows past the top and bottom are dead
	task automatic model_step();
		life_geom_pkg::row_t prev [ROWS];
		int n;
		int rr;
		int cc;
		prev = model;
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						rr = r + dr;
						cc = (c + dc + COLS) % COLS;
						if ((dr != 0 || dc != 0) && rr >= 0 && rr < ROWS) begin
							n += int'(prev[rr][cc]);
						end
					end
				end
				model[r][c] = (n == 3) || (prev[r][c] && n == 2);
			end
		end
	endtask

	//////////////////////////////
	// command port
	//////////////////////////////

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (!cmd_ready) begin
			@(posedge clk);
			#2;
			waited++;
			if (waited > TIMEOUT) begin
				$display("timeout: cmd_ready did not rise");
				fail_stop();
			end
		end
	endtask

	// held for one edge with cmd_ready known high
	task automatic issue_cmd(input logic [1:0] op);
		wait_ready();
		cmd_valid = 1'b1;
		cmd = op;
		@(posedge clk);
		#2;
		cmd_valid = 1'b0;
	endtask

	task automatic run_step();
		issue_cmd(life_ctrl_pkg::CMD_STEP);
		wait_ready();
		model_step();
		gen_expected++;
		check_value("gen_count", gen_count, gen_expected);
	endtask

	//////////////////////////////
	// read-out with credit return
	//////////////////////////////

	// hold: cycles with no credits returned, poke: offer a step meanwhile
	task automatic read_grid(input bit random_credits, input int hold, input bit poke);
		int got;
		int pending;
		int cycles;
		bit give;
		got = 0;
		pending = 0;
		cycles = 0;
		issue_cmd(life_ctrl_pkg::CMD_READ);
		while (got < ROWS || pending > 0) begin
			if (cycles < hold) begin
				credit_return = 1'b0;
				cmd_valid = poke;
				cmd = life_ctrl_pkg::CMD_STEP;
				if (poke) begin
					check_value("cmd_ready", 32'(cmd_ready), 32'd0);
				end
			end else begin
				cmd_valid = 1'b0;
				give = (pending > 0) && (!random_credits || ($urandom % 3) == 0);
				credit_return = give;
				if (give) begin
					pending--;
				end
			end
			@(posedge clk);
			#2;
			cycles++;
			if (row_valid) begin
				assert (got < ROWS) else begin
					$display("row_valid pulsed after the last row of the grid");
					fail_stop();
				end
				check_value("row_addr", 32'(row_addr), got);
				check_value("row_data", 32'(row_data), 32'(model[got]));
				got++;
				pending++;
			end
			// stalled consumer sees only the buffered rows
			if (hold > 0 && cycles == hold) begin
				check_value("row_valid count", got,
					int'(life_ctrl_pkg::CREDIT_MAX));
			end
			if (cycles > TIMEOUT) begin
				$display("timeout: read-out did not deliver the whole grid");
				fail_stop();
			end
		end
		credit_return = 1'b0;
		cmd_valid = 1'b0;
		// nothing more after the last row
		repeat (3) begin
			@(posedge clk);
			#2;
			check_value("row_valid", 32'(row_valid), 32'd0);
		end
		wait_ready();
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic test_reset_state();
		check_value("cmd_ready", 32'(cmd_ready), 32'd1);
		check_value("row_valid", 32'(row_valid), 32'd0);
		check_value("gen_count", gen_count, 32'd0);
	endtask

	task automatic test_seed_read();
		issue_cmd(life_ctrl_pkg::CMD_SEED);
		wait_ready();
		model_seed();
		read_grid(1'b0, 0, 1'b0);
	endtask

	task automatic test_one_step();
		run_step();
		read_grid(1'b0, 0, 1'b0);
	endtask

	task automatic test_back_pressure();
		read_grid(1'b0, 20, 1'b0);
	endtask

	task automatic test_random_steps();
		for (int i = 0; i < 5; i++) begin
			run_step();
			read_grid(1'b1, 0, 1'b0);
		end
	endtask

	// step offered while a stalled read holds the sequencer
	task automatic test_busy_cmd();
		read_grid(1'b0, 12, 1'b1);
		check_value("gen_count", gen_count, gen_expected);
		read_grid(1'b0, 0, 1'b0);
		check_value("gen_count", gen_count, gen_expected);
	endtask

	initial begin
		void'($urandom(29));
		clk = 1'b0;
		reset = 1'b1;
		cmd_valid = 1'b0;
		cmd = 2'd0;
		credit_return = 1'b0;
		lfsr_state = life_ctrl_pkg::LFSR_SEED;
		gen_expected = 32'd0;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		test_reset_state();
		test_seed_read();
		test_one_step();
		test_back_pressure();
		test_random_steps();
		test_busy_cmd();
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
src/life_geom_pkg.sv
src/life_ctrl_pkg.sv
src/cell_mem_if.sv
src/cell_ram.sv
src/seed_lfsr.sv
src/life_rule_pipe.sv
src/life_seq.sv
src/row_credit_out.sv
src/life_top.sv
tb/life_tb.sv

//--- run.sh
#!/bin/sh
# build and run the Life engine testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module life_tb -f tb.f -o life_sim
./obj_dir/life_sim
